// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths.
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // First instruction after reset.
  localparam addr_t RESET_PC = 32'h8000_0000;

  //////////////////////////////////////////////////////////////////////
  // L1 instruction cache geometry.
  //////////////////////////////////////////////////////////////////////

  // One word per line, so the index starts right above the byte offset.
  localparam int CACHE_LINES = 16;
  localparam int CACHE_IDX_W = 4;
  localparam int CACHE_TAG_W = ADDR_W - CACHE_IDX_W - 2;

  typedef logic [CACHE_IDX_W-1:0] cache_idx_t;
  typedef logic [CACHE_TAG_W-1:0] cache_tag_t;

  // Device window, addr[11:8] == 0xF, never cached.
  localparam int         DEV_LSB   = 8;
  localparam logic [3:0] DEV_MATCH = 4'hF;

  //////////////////////////////////////////////////////////////////////
  // Instruction encodings.
  //////////////////////////////////////////////////////////////////////

  localparam word_t      FENCE_I_WORD = 32'h0000_100f;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;

  // Fetch unit FSM.
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_BUS,
    HOLD
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== src/fetch_pc_gen.sv ====
`default_nettype none

module fetch_pc_gen (
  input  wire              clk,
  input  wire              rst,
  input  wire              redirect_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  input  wire              handoff_i,
  input  wire              jal_taken_i,
  input  wire fetch_pkg::addr_t jal_target_i,
  output logic             pc_valid_o,
  output fetch_pkg::addr_t pc_o
);
  import fetch_pkg::*;

  addr_t pc_q;
  logic  pc_valid_q;
  logic  started_q;
  logic  pend_q;
  addr_t pend_pc_q;
  addr_t next_pc;

  //////////////////////////////////////////////////////////////////////
  // Next PC selection.
  //////////////////////////////////////////////////////////////////////

  // A redirect in the handoff cycle wins over an older pending one.
  always_comb
  begin
    if (redirect_i)
      next_pc = redirect_pc_i;
    else if (pend_q)
      next_pc = pend_pc_q;
    else if (jal_taken_i)
      next_pc = jal_target_i;
    else
      next_pc = pc_q + 32'd4;
  end

  //////////////////////////////////////////////////////////////////////
  // PC register and pending redirect.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q       <= RESET_PC;
      pc_valid_q <= 1'b0;
      started_q  <= 1'b0;
      pend_q     <= 1'b0;
    end
    else
    begin
      started_q  <= 1'b1;
      // First pulse right after reset, then one per handoff.
      pc_valid_q <= !started_q || handoff_i;
      if (handoff_i)
      begin
        pc_q   <= next_pc;
        pend_q <= 1'b0;
      end
      else if (redirect_i)
        pend_q <= 1'b1;
    end
  end

  // Only the latest target is kept.
  always_ff @(posedge clk)
  begin
    if (redirect_i)
      pend_pc_q <= redirect_pc_i;
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;

  a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
    pc_valid_o |-> (pc_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
  input  wire              clk,
  input  wire              rst,
  input  wire              pc_valid_i,
  input  wire fetch_pkg::addr_t pc_i,
  output logic             bus_ar_valid_o,
  output fetch_pkg::addr_t bus_ar_addr_o,
  input  wire              bus_r_valid_i,
  input  wire fetch_pkg::word_t bus_r_data_i,
  output logic             fetch_valid_o,
  output fetch_pkg::word_t fetch_word_o,
  output fetch_pkg::addr_t fetch_pc_o
);
  import fetch_pkg::*;

  fetch_state_t state_q;
  addr_t        req_pc_q;
  logic         fetch_valid_q;
  word_t        fetch_word_q;

  logic [CACHE_LINES-1:0] line_valid_q;
  cache_tag_t             line_tag_q  [CACHE_LINES];
  word_t                  line_data_q [CACHE_LINES];

  cache_idx_t req_idx;
  cache_tag_t req_tag;
  logic       req_dev;
  logic       hit;
  logic       accept;
  logic       bus_done;
  logic       fence_ret;
  logic       fill;

  //////////////////////////////////////////////////////////////////////
  // Lookup.
  //////////////////////////////////////////////////////////////////////

  assign req_idx = req_pc_q[CACHE_IDX_W+1:2];
  assign req_tag = req_pc_q[ADDR_W-1:CACHE_IDX_W+2];
  assign req_dev = (req_pc_q[DEV_LSB+3:DEV_LSB] == DEV_MATCH);

  // Device space never hits, even if a stale line matches.
  assign hit = line_valid_q[req_idx] && (line_tag_q[req_idx] == req_tag) && !req_dev;

  assign accept    = pc_valid_i && ((state_q == IDLE) || (state_q == HOLD));
  assign bus_done  = (state_q == WAIT_BUS) && bus_r_valid_i;
  assign fence_ret = bus_done && (bus_r_data_i == FENCE_I_WORD);
  assign fill      = bus_done && !fence_ret && !req_dev;

  // Read request goes out already in the lookup cycle on a miss.
  assign bus_ar_valid_o = (state_q == WAIT_BUS) || ((state_q == LOOKUP) && !hit);
  assign bus_ar_addr_o  = req_pc_q;

  //////////////////////////////////////////////////////////////////////
  // Fetch FSM.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q       <= IDLE;
      fetch_valid_q <= 1'b0;
    end
    else
    begin
      fetch_valid_q <= 1'b0;
      case (state_q)
        IDLE, HOLD:
        begin
          if (pc_valid_i)
            state_q <= LOOKUP;
        end
        LOOKUP:
        begin
          if (hit)
          begin
            fetch_valid_q <= 1'b1;
            state_q       <= HOLD;
          end
          else
            state_q <= WAIT_BUS;
        end
        WAIT_BUS:
        begin
          if (bus_r_valid_i)
          begin
            fetch_valid_q <= 1'b1;
            state_q       <= HOLD;
          end
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      req_pc_q <= pc_i;
    if ((state_q == LOOKUP) && hit)
      fetch_word_q <= line_data_q[req_idx];
    else if (bus_done)
      fetch_word_q <= bus_r_data_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Cache fill and FENCE.I flush.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      line_valid_q <= '0;
    else if (fence_ret)
      line_valid_q <= '0;
    else if (fill)
      line_valid_q[req_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      line_tag_q[req_idx]  <= req_tag;
      line_data_q[req_idx] <= bus_r_data_i;
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_word_o  = fetch_word_q;
  assign fetch_pc_o    = req_pc_q;

  // Request must hold until the memory answers.
  a_ar_stable : assert property (@(posedge clk) disable iff (rst)
    (bus_ar_valid_o && !bus_r_valid_i) |=> (bus_ar_valid_o && $stable(bus_ar_addr_o)));

endmodule

`default_nettype wire

// ==== src/fetch_predecode.sv ====
`default_nettype none

module fetch_predecode (
  input  wire              clk,
  input  wire              rst,
  input  wire              fetch_valid_i,
  input  wire fetch_pkg::word_t fetch_word_i,
  input  wire fetch_pkg::addr_t fetch_pc_i,
  input  wire              out_ready_i,
  output logic             out_valid_o,
  output fetch_pkg::addr_t out_pc_o,
  output fetch_pkg::word_t out_instr_o,
  output logic             out_jal_o,
  output logic             handoff_o,
  output fetch_pkg::addr_t jal_target_o
);
  import fetch_pkg::*;

  logic  out_valid_q;
  addr_t out_pc_q;
  word_t out_instr_q;
  logic  out_jal_q;
  addr_t jal_target_q;
  addr_t j_imm;

  //////////////////////////////////////////////////////////////////////
  // JAL decode.
  //////////////////////////////////////////////////////////////////////

  // J-type immediate, sign extended from bit 20.
  assign j_imm = {{12{fetch_word_i[31]}},
                  fetch_word_i[19:12],
                  fetch_word_i[20],
                  fetch_word_i[30:21],
                  1'b0};

  //////////////////////////////////////////////////////////////////////
  // Output register.
  //////////////////////////////////////////////////////////////////////

  assign handoff_o = out_valid_q && out_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid_q <= 1'b0;
    else if (fetch_valid_i)
      out_valid_q <= 1'b1;
    else if (handoff_o)
      out_valid_q <= 1'b0;
  end

  // Target is formed on load so the handoff path stays short.
  always_ff @(posedge clk)
  begin
    if (fetch_valid_i)
    begin
      out_pc_q     <= fetch_pc_i;
      out_instr_q  <= fetch_word_i;
      out_jal_q    <= (fetch_word_i[6:0] == OPC_JAL);
      jal_target_q <= fetch_pc_i + j_imm;
    end
  end

  assign out_valid_o  = out_valid_q;
  assign out_pc_o     = out_pc_q;
  assign out_instr_o  = out_instr_q;
  assign out_jal_o    = out_jal_q;
  assign jal_target_o = jal_target_q;

  a_out_stable : assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_pc_o) && $stable(out_instr_o) && $stable(out_jal_o)));

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
`default_nettype none

module fetch_top (
  input  wire              clk,
  input  wire              rst,
  input  wire              redirect_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  output logic             bus_ar_valid_o,
  output fetch_pkg::addr_t bus_ar_addr_o,
  input  wire              bus_r_valid_i,
  input  wire fetch_pkg::word_t bus_r_data_i,
  input  wire              out_ready_i,
  output logic             out_valid_o,
  output fetch_pkg::addr_t out_pc_o,
  output fetch_pkg::word_t out_instr_o,
  output logic             out_jal_o
);
  import fetch_pkg::*;

  logic  pc_valid;
  addr_t pc;
  logic  fetch_valid;
  word_t fetch_word;
  addr_t fetch_pc;
  logic  handoff;
  addr_t jal_target;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .handoff_i     (handoff),
    .jal_taken_i   (out_jal_o),
    .jal_target_i  (jal_target),
    .pc_valid_o    (pc_valid),
    .pc_o          (pc)
  );

  fetch_unit u_fetch (
    .clk            (clk),
    .rst            (rst),
    .pc_valid_i     (pc_valid),
    .pc_i           (pc),
    .bus_ar_valid_o (bus_ar_valid_o),
    .bus_ar_addr_o  (bus_ar_addr_o),
    .bus_r_valid_i  (bus_r_valid_i),
    .bus_r_data_i   (bus_r_data_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_word_o   (fetch_word),
    .fetch_pc_o     (fetch_pc)
  );

  fetch_predecode u_predecode (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_word_i  (fetch_word),
    .fetch_pc_i    (fetch_pc),
    .out_ready_i   (out_ready_i),
    .out_valid_o   (out_valid_o),
    .out_pc_o      (out_pc_o),
    .out_instr_o   (out_instr_o),
    .out_jal_o     (out_jal_o),
    .handoff_o     (handoff),
    .jal_target_o  (jal_target)
  );

endmodule

`default_nettype wire

// ==== testbench/fetch_checker.sv ====
`default_nettype none

module fetch_checker #(
  parameter int MEM_WORDS = 1024
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire [2:0]             phase_i,
  input  wire fetch_pkg::word_t mem_i [MEM_WORDS],
  input  wire                   redirect_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  input  wire                   bus_ar_valid_i,
  input  wire fetch_pkg::addr_t bus_ar_addr_i,
  input  wire                   bus_r_valid_i,
  input  wire fetch_pkg::word_t bus_r_data_i,
  input  wire                   out_ready_i,
  input  wire                   out_valid_i,
  input  wire fetch_pkg::addr_t out_pc_i,
  input  wire fetch_pkg::word_t out_instr_i,
  input  wire                   out_jal_i,
  output int                    check_cnt_o,
  output int                    err_cnt_o
);
  import fetch_pkg::*;

  addr_t                  cur_pc;
  logic                   pred_hit;
  logic                   refetch;
  logic                   pend;
  addr_t                  pend_pc;
  logic [CACHE_LINES-1:0] m_valid;
  cache_tag_t             m_tag [CACHE_LINES];
  // Lines that held a word when the last FENCE.I came back.
  logic [CACHE_LINES-1:0] old_valid;
  cache_tag_t             old_tag [CACHE_LINES];
  int                     reads;
  addr_t                  read_addr;
  logic                   first_cycle;
  logic                   first_handoff;
  logic [2:0]             last_phase;
  int                     check_cnt;
  int                     err_cnt;
  int                     ph_handoffs;
  int                     ph_checks;
  int                     ph_errs;
  int                     ph_hits;
  int                     ph_dev;
  int                     ph_refetch;

  assign check_cnt_o = check_cnt;
  assign err_cnt_o   = err_cnt;

  function automatic logic in_dev_space(addr_t a);
    return a[11:8] == DEV_MATCH;
  endfunction

  function automatic addr_t jal_dest(addr_t pc, word_t w);
    logic [20:0] imm;
    imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    return pc + {{11{imm[20]}}, imm};
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    check_cnt = check_cnt + 1;
    ph_checks = ph_checks + 1;
    if (exp !== act)
    begin
      err_cnt = err_cnt + 1;
      ph_errs = ph_errs + 1;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Fetch model.
  //////////////////////////////////////////////////////////////////////

  task automatic start_fetch(addr_t pc);
    cache_idx_t idx;
    cache_tag_t tag;
    idx      = pc[5:2];
    tag      = pc[31:6];
    cur_pc   = pc;
    pred_hit = !in_dev_space(pc) && m_valid[idx] && (m_tag[idx] == tag);
    refetch  = !in_dev_space(pc) && old_valid[idx] && (old_tag[idx] == tag);
    reads    = 0;
  endtask

  task automatic bus_return();
    cache_idx_t idx;
    idx       = cur_pc[5:2];
    reads     = reads + 1;
    read_addr = bus_ar_addr_i;
    if (bus_r_data_i == FENCE_I_WORD)
    begin
      for (int i = 0; i < CACHE_LINES; i++)
      begin
        if (m_valid[i])
        begin
          old_valid[i] = 1'b1;
          old_tag[i]   = m_tag[i];
        end
      end
      m_valid = '0;
    end
    else if (!in_dev_space(cur_pc))
    begin
      m_valid[idx] = 1'b1;
      m_tag[idx]   = cur_pc[31:6];
    end
  endtask

  task automatic finish_fetch();
    word_t exp_word;
    addr_t next_pc;
    string pc_name;
    string rd_name;
    exp_word    = mem_i[cur_pc[11:2]];
    ph_handoffs = ph_handoffs + 1;
    pc_name     = first_handoff ? "reset_pc" : "pc_seq";
    check_value(pc_name, cur_pc, out_pc_i);
    check_value("instr_word", exp_word, out_instr_i);
    check_value("jal_flag", {31'd0, exp_word[6:0] == OPC_JAL}, {31'd0, out_jal_i});
    if (in_dev_space(cur_pc))
    begin
      rd_name = "dev_read";
      ph_dev  = ph_dev + 1;
    end
    else if (refetch)
    begin
      rd_name    = "fence_refetch";
      ph_refetch = ph_refetch + 1;
      old_valid[cur_pc[5:2]] = 1'b0;
    end
    else if (pred_hit)
    begin
      rd_name = "hit_no_read";
      ph_hits = ph_hits + 1;
    end
    else
      rd_name = "miss_read";
    check_value(rd_name, pred_hit ? 32'd0 : 32'd1, reads);
    if (reads > 0)
      check_value("read_addr", cur_pc, read_addr);
    // Latest redirect, then JAL target, then the next word.
    if (pend)
      next_pc = pend_pc;
    else if (exp_word[6:0] == OPC_JAL)
      next_pc = jal_dest(cur_pc, exp_word);
    else
      next_pc = cur_pc + 32'd4;
    pend          = 1'b0;
    first_handoff = 1'b0;
    start_fetch(next_pc);
  endtask

  task automatic report_phase(logic [2:0] p);
    string name;
    case (p)
      3'd1:    name = "no redirects";
      3'd2:    name = "with redirects";
      default: name = "device-heavy redirects";
    endcase
    $display("Phase %0d (%s): %0d handoffs, %0d checks, %0d errors, %0d hits, %0d device, %0d refetch",
             p, name, ph_handoffs, ph_checks, ph_errs, ph_hits, ph_dev, ph_refetch);
    ph_handoffs = 0;
    ph_checks   = 0;
    ph_errs     = 0;
    ph_hits     = 0;
    ph_dev      = 0;
    ph_refetch  = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watch the ports.
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    check_cnt   = 0;
    err_cnt     = 0;
    ph_handoffs = 0;
    ph_checks   = 0;
    ph_errs     = 0;
    ph_hits     = 0;
    ph_dev      = 0;
    ph_refetch  = 0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      m_valid       = '0;
      old_valid     = '0;
      pend          = 1'b0;
      first_cycle   = 1'b1;
      first_handoff = 1'b1;
      last_phase    = 3'd1;
      start_fetch(RESET_PC);
    end
    else
    begin
      if (first_cycle)
      begin
        check_value("reset_ar_valid", 32'd0, {31'd0, bus_ar_valid_i});
        check_value("reset_out_valid", 32'd0, {31'd0, out_valid_i});
        first_cycle = 1'b0;
      end
      if (phase_i != last_phase)
      begin
        report_phase(last_phase);
        last_phase = phase_i;
      end
      // A redirect in the handoff cycle still counts for that handoff.
      if (redirect_i)
      begin
        pend    = 1'b1;
        pend_pc = redirect_pc_i;
      end
      if (bus_r_valid_i)
        bus_return();
      if (out_valid_i && out_ready_i)
        finish_fetch();
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_top.sv ====
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int MEM_WORDS    = 1024;
  localparam int PHASE_LEN    = 400;
  localparam int NUM_HANDOFFS = 3 * PHASE_LEN;
  localparam int CLK_PERIOD   = 100;
  localparam int WORST_CYCLES = 12;
  localparam int TIMEOUT      = (NUM_HANDOFFS * WORST_CYCLES + 10) * CLK_PERIOD;

  logic  clk;
  logic  rst;
  logic  redirect;
  addr_t redirect_pc;
  logic  bus_ar_valid;
  addr_t bus_ar_addr;
  logic  bus_r_valid;
  word_t bus_r_data;
  logic  out_ready;
  logic  out_valid;
  addr_t out_pc;
  word_t out_instr;
  logic  out_jal;

  word_t      mem [MEM_WORDS];
  integer     seed;
  int         handoff_cnt;
  logic [2:0] phase;
  logic       mem_busy;
  int         mem_wait;
  addr_t      mem_addr;
  int         check_cnt;
  int         err_cnt;

  fetch_top UUT (
    .clk            (clk),
    .rst            (rst),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .bus_ar_valid_o (bus_ar_valid),
    .bus_ar_addr_o  (bus_ar_addr),
    .bus_r_valid_i  (bus_r_valid),
    .bus_r_data_i   (bus_r_data),
    .out_ready_i    (out_ready),
    .out_valid_o    (out_valid),
    .out_pc_o       (out_pc),
    .out_instr_o    (out_instr),
    .out_jal_o      (out_jal)
  );

  fetch_checker #(.MEM_WORDS(MEM_WORDS)) u_check (
    .clk            (clk),
    .rst            (rst),
    .phase_i        (phase),
    .mem_i          (mem),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .bus_ar_valid_i (bus_ar_valid),
    .bus_ar_addr_i  (bus_ar_addr),
    .bus_r_valid_i  (bus_r_valid),
    .bus_r_data_i   (bus_r_data),
    .out_ready_i    (out_ready),
    .out_valid_i    (out_valid),
    .out_pc_i       (out_pc),
    .out_instr_i    (out_instr),
    .out_jal_i      (out_jal),
    .check_cnt_o    (check_cnt),
    .err_cnt_o      (err_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory image.
  //////////////////////////////////////////////////////////////////////

  task automatic fill_memory();
    word_t       w;
    int          pick;
    int          offs;
    logic [20:0] imm;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      pick = rand_below(100);
      if (pick < 3)
        w = FENCE_I_WORD;
      else if (pick < 13)
      begin
        // Short jump either way, so loops form and lines get reused.
        offs = (rand_below(64) - 32) * 4;
        if (offs == 0)
          offs = 8;
        imm = offs[20:0];
        w = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
      end
      else
      begin
        w = $random(seed);
        if (w[6:0] == OPC_JAL)
          w[0] = 1'b0;
      end
      mem[i] = w;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////////////////////////

  task automatic drive_redirect();
    addr_t target;
    int    dev_share;
    if (((phase == 3'd2) || (phase == 3'd3)) && (rand_below(12) == 0))
    begin
      target       = RESET_PC;
      target[12]   = rand_below(2);
      target[11:2] = rand_below(MEM_WORDS);
      dev_share    = (phase == 3'd3) ? 2 : 8;
      if (rand_below(dev_share) == 0)
        target[11:8] = DEV_MATCH;
      redirect    <= 1'b1;
      redirect_pc <= target;
    end
    else
      redirect <= 1'b0;
  endtask

  // One read at a time, answered 1 to 6 cycles after it is seen.
  task automatic serve_bus();
    if (bus_r_valid)
      bus_r_valid <= 1'b0;
    else if (mem_busy)
    begin
      mem_wait = mem_wait - 1;
      if (mem_wait == 0)
      begin
        bus_r_valid <= 1'b1;
        bus_r_data  <= mem[mem_addr[11:2]];
        mem_busy = 1'b0;
      end
    end
    else if (bus_ar_valid)
    begin
      mem_busy = 1'b1;
      mem_addr = bus_ar_addr;
      mem_wait = 1 + rand_below(6);
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (out_valid && out_ready)
      begin
        handoff_cnt = handoff_cnt + 1;
        if ((handoff_cnt % PHASE_LEN) == 0)
          phase <= phase + 3'd1;
      end
      out_ready <= (rand_below(4) != 0);
      drive_redirect();
      serve_bus();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run control.
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed        = 60553;
    rst         = 1'b1;
    redirect    = 1'b0;
    redirect_pc = RESET_PC;
    bus_r_valid = 1'b0;
    bus_r_data  = '0;
    out_ready   = 1'b0;
    phase       = 3'd1;
    handoff_cnt = 0;
    mem_busy    = 1'b0;
    mem_wait    = 0;
    mem_addr    = '0;
    fill_memory();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait (phase == 3'd4);
    repeat (2) @(posedge clk);
    $display("Totals: %0d handoffs, %0d checks, %0d errors", handoff_cnt, check_cnt, err_cnt);
    if ((err_cnt == 0) && (check_cnt > 0))
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    #(TIMEOUT);
    $display("Timeout: only %0d of %0d handoffs completed", handoff_cnt, NUM_HANDOFFS);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_top.f ====
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_unit.sv
src/fetch_predecode.sv
src/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

dependencies: {}

sources:
  # Package first, then the leaf blocks, then the top level.
  - files:
      - src/fetch_pkg.sv
      - src/fetch_pc_gen.sv
      - src/fetch_unit.sv
      - src/fetch_predecode.sv
      - src/fetch_top.sv

  # Testbench, checker before the top module that instantiates it.
  - target: test
    files:
      - testbench/fetch_checker.sv
      - testbench/tb_fetch_top.sv
